// File: rv_core.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_alu.sv
rv_exec.sv
rv_lsu.sv
rv_core.sv
rv_tb_clk.sv
rv_tb_mem.sv
rv_tb_check.sv
rv_core_chk.sv
rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_alu.sv
  - rv_exec.sv
  - rv_lsu.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_tb_clk.sv
      - rv_tb_mem.sv
      - rv_tb_check.sv
      - rv_core_chk.sv
      - rv_core_tb.sv

// File: rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

  localparam int          num_tests = 4;
  localparam logic [63:0] data_word = 64'h8123_4567_fedc_ba98;

  logic        clk;
  logic        rst;
  wb_m2s_t     ibus_m2s;
  wb_m2s_t     dbus_m2s;
  logic        ibus_ack;
  logic        dbus_ack;
  logic [63:0] ibus_dat;
  logic [63:0] dbus_dat;
  logic        halt;
  logic        halt_fail;
  logic [31:0] words [$];
  logic [63:0] st_adr [$];
  logic [7:0]  st_sel [$];
  logic [63:0] st_dat [$];
  logic        exp_fail;
  int          slot;
  int          timeout_cycles = 0;

  rv_tb_clk u_clk (.clk(clk), .rst(rst));

  rv_core #(.reset_pc(64'h0)) dut0 (
    .clk       (clk),
    .rst       (rst),
    .ibus_m2s  (ibus_m2s),
    .ibus_ack  (ibus_ack),
    .ibus_dat  (ibus_dat),
    .dbus_m2s  (dbus_m2s),
    .dbus_ack  (dbus_ack),
    .dbus_dat  (dbus_dat),
    .halt      (halt),
    .halt_fail (halt_fail)
  );

  rv_tb_mem u_mem (
    .clk      (clk),
    .ibus_m2s (ibus_m2s),
    .ibus_ack (ibus_ack),
    .ibus_dat (ibus_dat),
    .dbus_m2s (dbus_m2s),
    .dbus_ack (dbus_ack),
    .dbus_dat (dbus_dat)
  );

  rv_tb_check u_check (
    .clk       (clk),
    .rst       (rst),
    .ibus_m2s  (ibus_m2s),
    .dbus_m2s  (dbus_m2s),
    .dbus_ack  (dbus_ack),
    .halt      (halt),
    .halt_fail (halt_fail)
  );

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] w);
    words.push_back(w);
  endtask

  task automatic expect_store(input logic [63:0] adr, input logic [7:0] sel,
                              input logic [63:0] dat);
    st_adr.push_back(adr);
    st_sel.push_back(sel);
    st_dat.push_back(dat);
  endtask

  // sd rs2 into the next result slot above 0x100
  task automatic store_slot(input logic [4:0] rs2, input logic [63:0] value);
    emit(enc_s(slot * 8, rs2, 5, 3'd3));
    expect_store(64'h100 + slot * 8, 8'hff, value);
    slot++;
  endtask

  task automatic alu_case(input logic [31:0] w, input logic [63:0] value);
    emit(w);
    store_slot(20, value);
  endtask

  // sits on a path that must never execute
  task automatic skipped_store();
    emit(enc_s(12'h0f8, 6, 5, 3'd3));
  endtask

  task automatic build_test(input int t);
    int pc_at;
    words.delete();
    st_adr.delete();
    st_sel.delete();
    st_dat.delete();
    slot     = 0;
    exp_fail = 1'b0;
    emit(enc_i(12'h100, 0, 3'd0, 5, 7'h13));
    emit(enc_i(12'hff9, 0, 3'd0, 6, 7'h13));
    emit(enc_i(12'd3, 0, 3'd0, 7, 7'h13));
    case (t)
      0: begin
        emit(enc_u(20'h7ffff, 9, 7'h37));
        emit(enc_u(20'h80000, 14, 7'h37));
        alu_case(enc_r(7'h00, 7, 6, 3'd0, 20, 7'h33), 64'hffff_ffff_ffff_fffc);
        alu_case(enc_r(7'h20, 7, 6, 3'd0, 20, 7'h33), 64'hffff_ffff_ffff_fff6);
        alu_case(enc_r(7'h00, 7, 6, 3'd7, 20, 7'h33), 64'h1);
        alu_case(enc_r(7'h00, 7, 6, 3'd6, 20, 7'h33), 64'hffff_ffff_ffff_fffb);
        alu_case(enc_r(7'h00, 7, 6, 3'd4, 20, 7'h33), 64'hffff_ffff_ffff_fffa);
        alu_case(enc_r(7'h00, 7, 6, 3'd2, 20, 7'h33), 64'h1);
        alu_case(enc_r(7'h00, 7, 6, 3'd3, 20, 7'h33), 64'h0);
        alu_case(enc_r(7'h00, 7, 6, 3'd1, 20, 7'h33), 64'hffff_ffff_ffff_ffc8);
        alu_case(enc_r(7'h00, 7, 6, 3'd5, 20, 7'h33), 64'h1fff_ffff_ffff_ffff);
        alu_case(enc_r(7'h20, 7, 6, 3'd5, 20, 7'h33), 64'hffff_ffff_ffff_ffff);
        alu_case(enc_r(7'h00, 9, 9, 3'd0, 20, 7'h3b), 64'hffff_ffff_ffff_e000);
        alu_case(enc_r(7'h00, 7, 9, 3'd1, 20, 7'h3b), 64'hffff_ffff_ffff_8000);
        alu_case(enc_i(12'hfff, 14, 3'd0, 20, 7'h1b), 64'h0000_0000_7fff_ffff);
        alu_case(enc_i(12'd40, 7, 3'd1, 20, 7'h13), 64'h0000_0300_0000_0000);
        alu_case(enc_i(12'h404, 14, 3'd5, 20, 7'h13), 64'hffff_ffff_f800_0000);
        store_slot(14, 64'hffff_ffff_8000_0000);
        emit(enc_i(12'd0, 0, 3'd0, 10, 7'h13));
        emit(32'h0010_0073);
      end
      1: begin
        emit(enc_i(12'h200, 0, 3'd0, 8, 7'h13));
        alu_case(enc_i(12'd0, 8, 3'd3, 20, 7'h03), data_word);
        alu_case(enc_i(12'd0, 8, 3'd2, 20, 7'h03), 64'hffff_ffff_fedc_ba98);
        alu_case(enc_i(12'd4, 8, 3'd2, 20, 7'h03), 64'hffff_ffff_8123_4567);
        for (int k = 0; k < 8; k++) begin
          alu_case(enc_i(k, 8, 3'd4, 20, 7'h03), {56'd0, data_word[8*k +: 8]});
        end
        // write to x0 must be lost
        emit(enc_i(12'd5, 0, 3'd0, 0, 7'h13));
        store_slot(0, 64'h0);
        emit(enc_s(12'h082, 6, 5, 3'd1));
        expect_store(64'h180, 8'h0c, 64'h0000_0000_fff9_0000);
        emit(enc_s(12'h086, 6, 5, 3'd1));
        expect_store(64'h180, 8'hc0, 64'hfff9_0000_0000_0000);
        emit(enc_i(12'd0, 0, 3'd0, 10, 7'h13));
        emit(32'h0010_0073);
      end
      2: begin
        pc_at = words.size() * 4;
        emit(enc_j(21'd8, 20));
        skipped_store();
        store_slot(20, pc_at + 4);
        pc_at = words.size() * 4;
        emit(enc_u(20'h0, 21, 7'h17));
        emit(enc_i(12'd13, 21, 3'd0, 20, 7'h67));
        skipped_store();
        store_slot(20, pc_at + 8);
        store_slot(21, pc_at);
        emit(enc_b(13'd8, 7, 7, 3'd0));
        skipped_store();
        emit(enc_b(13'd8, 7, 6, 3'd0));
        store_slot(7, 64'd3);
        emit(enc_b(13'd8, 7, 6, 3'd1));
        skipped_store();
        emit(enc_b(13'd8, 7, 7, 3'd1));
        store_slot(6, -64'sd7);
        emit(enc_i(12'd1, 0, 3'd0, 10, 7'h13));
        emit(32'h0010_0073);
        exp_fail = 1'b1;
      end
      default: begin
        store_slot(6, -64'sd7);
        emit(32'hffff_ffff);
        exp_fail = 1'b1;
      end
    endcase
  endtask

  task automatic load_memory();
    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i] = {32'hc0de_0000 ^ 32'(i), 32'(i) * 32'h9e37_79b9};
    end
    for (int k = 0; k < words.size(); k++) begin
      u_mem.mem[k / 2][32 * (k % 2) +: 32] = words[k];
    end
    u_mem.mem[64] = data_word;
  endtask

  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout after %0d cycles without reaching the end of the tests", timeout_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int total_words;
    total_words = 0;
    for (int t = 0; t < num_tests; t++) begin
      build_test(t);
      total_words += words.size();
    end
    timeout_cycles = total_words * 40 + 200;
    for (int t = 0; t < num_tests; t++) begin
      build_test(t);
      load_memory();
      for (int k = 0; k < st_adr.size(); k++) begin
        u_check.expect_store(st_adr[k], st_sel[k], st_dat[k]);
      end
      u_clk.pulse_reset();
      while (!halt) @(posedge clk);
      // idle cycles so late bus activity is caught
      repeat (10) @(posedge clk);
      u_check.end_test(t, exp_fail);
    end
    $display("errors: value %0d, other %0d", u_check.value_errors, u_check.other_errors);
    if (u_check.value_errors == 0 && u_check.other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: rv_core_chk.sv
module rv_core_chk import rv_pkg::*; (
  input logic    clk,
  input logic    rst,
  input wb_m2s_t ibus_m2s,
  input logic    ibus_ack,
  input wb_m2s_t dbus_m2s,
  input logic    dbus_ack,
  input logic    mem_start,
  input dec_t    dec
);

  a_ibus_stb_cyc: assert property (@(posedge clk) disable iff (rst)
    ibus_m2s.stb |-> ibus_m2s.cyc) else $error("ibus stb without cyc");

  a_dbus_stb_cyc: assert property (@(posedge clk) disable iff (rst)
    dbus_m2s.stb |-> dbus_m2s.cyc) else $error("dbus stb without cyc");

  a_ibus_hold: assert property (@(posedge clk) disable iff (rst)
    (ibus_m2s.stb && !ibus_ack) |=>
      $stable({ibus_m2s.adr, ibus_m2s.we, ibus_m2s.dat, ibus_m2s.sel}))
    else $error("ibus request changed before ack");

  a_dbus_hold: assert property (@(posedge clk) disable iff (rst)
    (dbus_m2s.stb && !dbus_ack) |=>
      $stable({dbus_m2s.adr, dbus_m2s.we, dbus_m2s.dat, dbus_m2s.sel}))
    else $error("dbus request changed before ack");

  // x0 as store source must reach the bus as zero
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (mem_start && dec.is_store && dec.rs2 == 5'd0) |=> (dbus_m2s.dat == 64'd0))
    else $error("store of x0 carried non-zero data");

endmodule

bind rv_core rv_core_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .ibus_m2s  (ibus_m2s),
  .ibus_ack  (ibus_ack),
  .dbus_m2s  (dbus_m2s),
  .dbus_ack  (dbus_ack),
  .mem_start (mem_start),
  .dec       (dec)
);

// File: rv_tb_check.sv
module rv_tb_check import rv_pkg::*; (
  input logic    clk,
  input logic    rst,
  input wb_m2s_t ibus_m2s,
  input wb_m2s_t dbus_m2s,
  input logic    dbus_ack,
  input logic    halt,
  input logic    halt_fail
);

  int          value_errors = 0;
  int          other_errors = 0;
  logic [63:0] exp_adr [$];
  logic [7:0]  exp_sel [$];
  logic [63:0] exp_dat [$];

  function automatic logic [63:0] lane_mask(input logic [7:0] sel);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("error time %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_store(input logic [63:0] adr, input logic [7:0] sel,
                              input logic [63:0] dat);
    exp_adr.push_back(adr);
    exp_sel.push_back(sel);
    exp_dat.push_back(dat);
  endtask

  always @(posedge clk) begin
    if (!rst && dbus_m2s.cyc && dbus_m2s.we && dbus_ack) begin
      if (exp_adr.size() == 0) begin
        other_errors++;
        $display("unexpected store at time %0t to address %h", $time, dbus_m2s.adr);
      end else begin
        check_value("dbus_adr", exp_adr[0], dbus_m2s.adr);
        check_value("dbus_sel", {56'd0, exp_sel[0]}, {56'd0, dbus_m2s.sel});
        // only the enabled lanes carry data
        check_value("dbus_dat", exp_dat[0] & lane_mask(exp_sel[0]),
                    dbus_m2s.dat & lane_mask(dbus_m2s.sel));
        void'(exp_adr.pop_front());
        void'(exp_sel.pop_front());
        void'(exp_dat.pop_front());
      end
    end
    if (!rst && halt && (ibus_m2s.cyc || dbus_m2s.cyc)) begin
      other_errors++;
      $display("bus cycle seen after halt at time %0t", $time);
    end
  end

  task automatic end_test(input int t, input logic exp_fail);
    if (exp_adr.size() != 0) begin
      other_errors++;
      $display("test %0d halted with %0d stores still missing", t, exp_adr.size());
    end
    exp_adr.delete();
    exp_sel.delete();
    exp_dat.delete();
    check_value("halt_fail", {63'd0, exp_fail}, {63'd0, halt_fail});
  endtask

endmodule

// File: rv_tb_mem.sv
module rv_tb_mem import rv_pkg::*; (
  input  logic        clk,
  input  wb_m2s_t     ibus_m2s,
  output logic        ibus_ack,
  output logic [63:0] ibus_dat,
  input  wb_m2s_t     dbus_m2s,
  output logic        dbus_ack,
  output logic [63:0] dbus_dat
);

  // 2 KiB shared by both ports
  logic [63:0] mem [256];
  integer      seed = 32'ha911_ed7d;
  int          iwait;
  int          dwait;

  initial begin
    ibus_ack = 1'b0;
    dbus_ack = 1'b0;
    ibus_dat = '0;
    dbus_dat = '0;
    iwait    = 0;
    dwait    = 0;
  end

  always @(posedge clk) begin
    if (ibus_ack) begin
      ibus_ack <= #10 1'b0;
      iwait = $unsigned($random(seed)) % 4;
    end else if (ibus_m2s.cyc && ibus_m2s.stb) begin
      if (iwait == 0) begin
        ibus_ack <= #10 1'b1;
        ibus_dat <= #10 mem[ibus_m2s.adr[10:3]];
      end else begin
        iwait = iwait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (dbus_ack) begin
      dbus_ack <= #10 1'b0;
      dwait = $unsigned($random(seed)) % 4;
    end else if (dbus_m2s.cyc && dbus_m2s.stb) begin
      if (dwait == 0) begin
        dbus_ack <= #10 1'b1;
        dbus_dat <= #10 mem[dbus_m2s.adr[10:3]];
        if (dbus_m2s.we) begin
          for (int b = 0; b < 8; b++) begin
            if (dbus_m2s.sel[b]) begin
              mem[dbus_m2s.adr[10:3]][8*b +: 8] = dbus_m2s.dat[8*b +: 8];
            end
          end
        end
      end else begin
        dwait = dwait - 1;
      end
    end
  end

endmodule

// File: rv_tb_clk.sv
module rv_tb_clk (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
  end

  always #50 clk = ~clk;

  task automatic pulse_reset();
    @(posedge clk);
    #10 rst = 1'b1;
    repeat (5) @(posedge clk);
    #10 rst = 1'b0;
  endtask

endmodule

// File: rv_core.sv
module rv_core import rv_pkg::*; #(
  parameter logic [63:0] reset_pc = 64'h0
) (
  input  logic        clk,
  input  logic        rst,
  output wb_m2s_t     ibus_m2s,
  input  logic        ibus_ack,
  input  logic [63:0] ibus_dat,
  output wb_m2s_t     dbus_m2s,
  input  logic        dbus_ack,
  input  logic [63:0] dbus_dat,
  output logic        halt,
  output logic        halt_fail
);

  logic [31:0] instr;
  logic        instr_valid;
  logic        take;
  logic [63:0] next_pc;
  logic [63:0] pc;
  dec_t        dec;
  logic        mem_start;
  mem_req_t    mem_req;
  logic        mem_done;
  logic [63:0] load_data;

  rv_fetch #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .take        (take),
    .next_pc     (next_pc),
    .instr       (instr),
    .instr_valid (instr_valid),
    .ibus_m2s    (ibus_m2s),
    .ibus_ack    (ibus_ack),
    .ibus_dat    (ibus_dat),
    .pc          (pc)
  );

  rv_decode u_decode (
    .instr (instr),
    .dec   (dec)
  );

  rv_exec u_exec (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec),
    .pc          (pc),
    .instr_valid (instr_valid),
    .take        (take),
    .next_pc     (next_pc),
    .mem_start   (mem_start),
    .mem_req     (mem_req),
    .mem_done    (mem_done),
    .load_data   (load_data),
    .halt        (halt),
    .halt_fail   (halt_fail)
  );

  rv_lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .mem_start (mem_start),
    .mem_req   (mem_req),
    .mem_done  (mem_done),
    .load_data (load_data),
    .dbus_m2s  (dbus_m2s),
    .dbus_ack  (dbus_ack),
    .dbus_dat  (dbus_dat)
  );

endmodule

// File: rv_lsu.sv
module rv_lsu import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_start,
  input  mem_req_t    mem_req,
  output logic        mem_done,
  output logic [63:0] load_data,
  output wb_m2s_t     dbus_m2s,
  input  logic        dbus_ack,
  input  logic [63:0] dbus_dat
);

  logic        cyc;
  logic        we_q;
  logic [63:0] adr_q;
  logic [63:0] dat_q;
  logic [7:0]  sel_q;
  logic [2:0]  off_q;
  mem_op_e     kind_q;
  logic [7:0]  sel;
  logic [63:0] wdata;
  logic [31:0] word;
  logic [63:0] lane_bytes;

  always_comb begin
    wdata = mem_req.wdata;
    case (mem_req.kind)
      mem_lw:  sel = mem_req.addr[2] ? 8'hf0 : 8'h0f;
      mem_lbu: sel = 8'h01 << mem_req.addr[2:0];
      mem_sh: begin
        sel   = 8'h03 << {mem_req.addr[2:1], 1'b0};
        wdata = {48'd0, mem_req.wdata[15:0]} << {mem_req.addr[2:1], 4'b0000};
      end
      default: sel = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc      <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= cyc && dbus_ack;
      if (mem_start) begin
        cyc <= 1'b1;
      end else if (dbus_ack) begin
        cyc <= 1'b0;
      end
    end
  end

  // request held steady for the whole bus cycle
  always_ff @(posedge clk) begin
    if (mem_start) begin
      kind_q <= mem_req.kind;
      off_q  <= mem_req.addr[2:0];
      adr_q  <= {mem_req.addr[63:3], 3'b000};
      we_q   <= (mem_req.kind == mem_sd) || (mem_req.kind == mem_sh);
      sel_q  <= sel;
      dat_q  <= wdata;
    end
  end

  assign word       = off_q[2] ? dbus_dat[63:32] : dbus_dat[31:0];
  assign lane_bytes = dbus_dat >> {off_q, 3'b000};

  always_ff @(posedge clk) begin
    if (cyc && dbus_ack) begin
      case (kind_q)
        mem_lw:  load_data <= {{32{word[31]}}, word};
        mem_lbu: load_data <= {56'd0, lane_bytes[7:0]};
        default: load_data <= dbus_dat;
      endcase
    end
  end

  assign dbus_m2s.cyc = cyc;
  assign dbus_m2s.stb = cyc;
  assign dbus_m2s.we  = we_q;
  assign dbus_m2s.adr = adr_q;
  assign dbus_m2s.dat = dat_q;
  assign dbus_m2s.sel = sel_q;

endmodule

// File: rv_exec.sv
module rv_exec import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  dec_t        dec,
  input  logic [63:0] pc,
  input  logic        instr_valid,
  output logic        take,
  output logic [63:0] next_pc,
  output logic        mem_start,
  output mem_req_t    mem_req,
  input  logic        mem_done,
  input  logic [63:0] load_data,
  output logic        halt,
  output logic        halt_fail
);

  typedef enum logic [2:0] {
    st_wait,
    st_exec,
    st_mem,
    st_retire,
    st_halt
  } state_e;

  state_e      state;
  logic [63:0] regs [32];
  logic [63:0] rs1_val;
  logic [63:0] rs2_val;
  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] alu_y;
  logic [63:0] pc_plus4;
  logic [63:0] wb_data;
  logic        stop;
  logic        mem_access;
  logic        taken;

  // x0 is never written, so its read is forced
  assign rs1_val = (dec.rs1 == 5'd0) ? 64'd0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? 64'd0 : regs[dec.rs2];

  assign op_a = (dec.op == op_auipc || dec.op == op_jal) ? pc : rs1_val;
  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  rv_alu u_alu (
    .mode (dec.alu_mode),
    .a    (op_a),
    .b    (op_b),
    .y    (alu_y)
  );

  assign pc_plus4   = pc + 64'd4;
  assign stop       = (dec.op == op_ebreak) || (dec.op == op_illegal);
  assign mem_access = dec.is_load || dec.is_store;
  // branch compares by subtraction
  assign taken      = dec.is_branch && ((alu_y == 64'd0) ^ (dec.op == op_bne));

  always_comb begin
    if (dec.is_jump) begin
      next_pc = (dec.op == op_jalr) ? {alu_y[63:1], 1'b0} : alu_y;
    end else if (taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    if (dec.is_jump) begin
      wb_data = pc_plus4;
    end else if (dec.op == op_lui) begin
      wb_data = dec.imm;
    end else if (dec.is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_y;
    end
  end

  always_comb begin
    case (dec.op)
      op_lw:   mem_req.kind = mem_lw;
      op_lbu:  mem_req.kind = mem_lbu;
      op_sd:   mem_req.kind = mem_sd;
      op_sh:   mem_req.kind = mem_sh;
      default: mem_req.kind = mem_ld;
    endcase
    mem_req.addr  = alu_y;
    mem_req.wdata = rs2_val;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_wait;
      halt_fail <= 1'b0;
    end else begin
      case (state)
        st_wait: begin
          if (instr_valid) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          if (stop) begin
            state     <= st_halt;
            // a0 carries the exit code
            halt_fail <= (dec.op == op_illegal) || (regs[10] != 64'd0);
          end else if (mem_access) begin
            state <= st_mem;
          end else begin
            state <= st_retire;
          end
        end
        st_mem: begin
          if (mem_done) begin
            state <= st_retire;
          end
        end
        st_retire: state <= st_wait;
        default:   state <= st_halt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_retire && dec.reg_write && dec.rd != 5'd0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  assign take      = (state == st_retire);
  assign mem_start = (state == st_exec) && !stop && mem_access;
  assign halt      = (state == st_halt);

endmodule

// File: rv_alu.sv
module rv_alu import rv_pkg::*; (
  input  alu_mode_e   mode,
  input  logic [63:0] a,
  input  logic [63:0] b,
  output logic [63:0] y
);

  logic [31:0] add_w;
  logic [31:0] sll_w;
  logic [5:0]  shamt;

  assign shamt = b[5:0];

  // word forms work on the low half only
  assign add_w = a[31:0] + b[31:0];
  assign sll_w = a[31:0] << b[4:0];

  always_comb begin
    case (mode)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_and:  y = a & b;
      alu_or:   y = a | b;
      alu_xor:  y = a ^ b;
      alu_slt:  y = {63'd0, $signed(a) < $signed(b)};
      alu_sltu: y = {63'd0, a < b};
      alu_sll:  y = a << shamt;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = $unsigned($signed(a) >>> shamt);
      alu_addw: y = {{32{add_w[31]}}, add_w};
      alu_sllw: y = {{32{sll_w[31]}}, sll_w};
      default:  y = a + b;
    endcase
  end

endmodule

// File: rv_decode.sv
module rv_decode import rv_pkg::*; (
  input  logic [31:0] instr,
  output dec_t        dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  rv_op_e      op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'h000};
  assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op = op_illegal;
    case (opcode)
      7'b0110011: begin
        case ({funct7, funct3})
          10'b0000000_000: op = op_add;
          10'b0100000_000: op = op_sub;
          10'b0000000_001: op = op_sll;
          10'b0000000_010: op = op_slt;
          10'b0000000_011: op = op_sltu;
          10'b0000000_100: op = op_xor;
          10'b0000000_101: op = op_srl;
          10'b0100000_101: op = op_sra;
          10'b0000000_110: op = op_or;
          10'b0000000_111: op = op_and;
          default:         op = op_illegal;
        endcase
      end
      7'b0111011: begin
        if ({funct7, funct3} == 10'b0000000_000) begin
          op = op_addw;
        end else if ({funct7, funct3} == 10'b0000000_001) begin
          op = op_sllw;
        end
      end
      7'b0010011: begin
        // rv64 shifts carry a six bit shamt, so funct6 is checked
        if (funct3 == 3'd0) begin
          op = op_addi;
        end else if (funct3 == 3'd1 && instr[31:26] == 6'b000000) begin
          op = op_slli;
        end else if (funct3 == 3'd5 && instr[31:26] == 6'b010000) begin
          op = op_srai;
        end
      end
      7'b0011011: op = (funct3 == 3'd0) ? op_addiw : op_illegal;
      7'b0110111: op = op_lui;
      7'b0010111: op = op_auipc;
      7'b1101111: op = op_jal;
      7'b1100111: op = (funct3 == 3'd0) ? op_jalr : op_illegal;
      7'b1100011: begin
        if (funct3 == 3'd0) begin
          op = op_beq;
        end else if (funct3 == 3'd1) begin
          op = op_bne;
        end
      end
      7'b0000011: begin
        case (funct3)
          3'd3:    op = op_ld;
          3'd2:    op = op_lw;
          3'd4:    op = op_lbu;
          default: op = op_illegal;
        endcase
      end
      7'b0100011: begin
        if (funct3 == 3'd3) begin
          op = op_sd;
        end else if (funct3 == 3'd1) begin
          op = op_sh;
        end
      end
      7'b1110011: op = (instr == 32'h0010_0073) ? op_ebreak : op_illegal;
      default:    op = op_illegal;
    endcase
  end

  always_comb begin
    dec.op        = op;
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.is_load   = op inside {op_ld, op_lw, op_lbu};
    dec.is_store  = op inside {op_sd, op_sh};
    dec.is_branch = op inside {op_beq, op_bne};
    dec.is_jump   = op inside {op_jal, op_jalr};
    dec.use_imm   = op inside {op_addi, op_addiw, op_slli, op_srai, op_auipc, op_jal,
                               op_jalr, op_ld, op_lw, op_lbu, op_sd, op_sh};
    dec.reg_write = !(dec.is_store || dec.is_branch || op == op_ebreak || op == op_illegal);
    dec.rd        = dec.reg_write ? instr[11:7] : 5'd0;

    case (op)
      op_sd, op_sh:     dec.imm = imm_s;
      op_beq, op_bne:   dec.imm = imm_b;
      op_lui, op_auipc: dec.imm = imm_u;
      op_jal:           dec.imm = imm_j;
      default:          dec.imm = imm_i;
    endcase

    case (op)
      op_sub, op_beq, op_bne: dec.alu_mode = alu_sub;
      op_and:                 dec.alu_mode = alu_and;
      op_or:                  dec.alu_mode = alu_or;
      op_xor:                 dec.alu_mode = alu_xor;
      op_slt:                 dec.alu_mode = alu_slt;
      op_sltu:                dec.alu_mode = alu_sltu;
      op_sll, op_slli:        dec.alu_mode = alu_sll;
      op_srl:                 dec.alu_mode = alu_srl;
      op_sra, op_srai:        dec.alu_mode = alu_sra;
      op_addw, op_addiw:      dec.alu_mode = alu_addw;
      op_sllw:                dec.alu_mode = alu_sllw;
      default:                dec.alu_mode = alu_add;
    endcase
  end

endmodule

// File: rv_fetch.sv
module rv_fetch import rv_pkg::*; #(
  parameter logic [63:0] reset_pc = 64'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        take,
  input  logic [63:0] next_pc,
  output logic [31:0] instr,
  output logic        instr_valid,
  output wb_m2s_t     ibus_m2s,
  input  logic        ibus_ack,
  input  logic [63:0] ibus_dat,
  output logic [63:0] pc
);

  logic start;
  logic cyc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= reset_pc;
      cyc         <= 1'b0;
      instr_valid <= 1'b0;
      start       <= 1'b1;
    end else begin
      start <= 1'b0;
      // first fetch after reset, then one per retired instruction
      if (start || take) begin
        cyc <= 1'b1;
      end else if (cyc && ibus_ack) begin
        cyc <= 1'b0;
      end
      if (take) begin
        pc          <= next_pc;
        instr_valid <= 1'b0;
      end else if (cyc && ibus_ack) begin
        instr_valid <= 1'b1;
      end
    end
  end

  // pick the half of the doubleword addressed by pc
  always_ff @(posedge clk) begin
    if (cyc && ibus_ack) begin
      instr <= pc[2] ? ibus_dat[63:32] : ibus_dat[31:0];
    end
  end

  assign ibus_m2s.cyc = cyc;
  assign ibus_m2s.stb = cyc;
  assign ibus_m2s.we  = 1'b0;
  assign ibus_m2s.adr = {pc[63:3], 3'b000};
  assign ibus_m2s.dat = '0;
  assign ibus_m2s.sel = 8'hff;

endmodule

// File: rv_pkg.sv
package rv_pkg;

  // one member per supported instruction
  typedef enum logic [5:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sltu,
    op_sll,
    op_srl,
    op_sra,
    op_addw,
    op_sllw,
    op_addi,
    op_addiw,
    op_slli,
    op_srai,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_ld,
    op_lw,
    op_lbu,
    op_sd,
    op_sh,
    op_ebreak,
    op_illegal
  } rv_op_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_addw,
    alu_sllw
  } alu_mode_e;

  typedef struct packed {
    rv_op_e      op;
    alu_mode_e   alu_mode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [63:0] imm;
    logic        use_imm;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_jump;
  } dec_t;

  typedef enum logic [2:0] {
    mem_ld,
    mem_lw,
    mem_lbu,
    mem_sd,
    mem_sh
  } mem_op_e;

  typedef struct packed {
    mem_op_e     kind;
    logic [63:0] addr;
    logic [63:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [63:0] adr;
    logic [63:0] dat;
    logic [7:0]  sel;
  } wb_m2s_t;

endpackage
